// File: mem_pkg.sv
package mem_pkg;

    // data path and address width
    localparam int data_w     = 32;
    // ram word index, 4096 words
    localparam int ram_addr_w = 12;

    // load/store operation, as decoded by the core
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } ldst_op_t;

    // upper half of the address that selects io
    localparam logic [15:0] io_prefix = 16'hffff;

    // memory mapped registers
    localparam logic [data_w-1:0] switches_addr = 32'hffff_ff00;
    localparam logic [data_w-1:0] led_addr      = 32'hffff_ff04;

endpackage

// File: dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
    input  logic                         clkb,
    // fetch port, read only
    input  logic [mem_pkg::ram_addr_w-1:0] addra,
    output logic [mem_pkg::data_w-1:0]     dataa,
    // load/store port
    input  logic [mem_pkg::ram_addr_w-1:0] addrb,
    input  logic                         web,
    input  logic [mem_pkg::data_w-1:0]     write_datab,
    output logic [mem_pkg::data_w-1:0]     datab
);
    import mem_pkg::*;

    localparam int depth = 2 ** ram_addr_w;

    logic [data_w-1:0] mem [depth];

    // fetch side, registered
    always_ff @(posedge clkb) begin
        dataa <= mem[addra];  // old word on a same-cycle write
    end

    // read-first on port b
    always_ff @(posedge clkb) begin
        datab <= mem[addrb];
        if (web) begin
            mem[addrb] <= write_datab;
        end
    end

endmodule

// File: load_align.sv
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::ldst_op_t            ldst,
    input  logic [1:0]                   byte_off,
    input  logic [mem_pkg::data_w-1:0]   word,
    output logic [mem_pkg::data_w-1:0]   result
);
    import mem_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane pick from the byte offset
    always_comb begin
        byte_lane = word[{byte_off, 3'b000} +: 8];
        half_lane = byte_off[1] ? word[31:16] : word[15:0];  // bit 0 ignored
    end

    always_comb begin
        case (ldst)
            op_lb: begin
                result = {{(data_w-8){byte_lane[7]}}, byte_lane};
            end
            op_lbu: begin
                result = {{(data_w-8){1'b0}}, byte_lane};
            end
            op_lh: begin
                result = {{(data_w-16){half_lane[15]}}, half_lane};
            end
            op_lhu: begin
                result = {{(data_w-16){1'b0}}, half_lane};
            end
            // lw, and the raw word for anything else
            default: begin
                result = word;
            end
        endcase
    end

endmodule

// File: store_merge.sv
`timescale 1ns/1ps

module store_merge (
    input  mem_pkg::ldst_op_t            ldst,
    input  logic [1:0]                   byte_off,
    input  logic [mem_pkg::data_w-1:0]   old_word,
    input  logic [mem_pkg::data_w-1:0]   store_data,
    output logic [mem_pkg::data_w-1:0]   new_word
);
    import mem_pkg::*;

    // read-modify-write merge for sub-word stores
    always_comb begin
        new_word = old_word;
        case (ldst)
            op_sw: begin
                new_word = store_data;
            end
            op_sh: begin
                if (byte_off[1]) begin
                    new_word[31:16] = store_data[15:0];  // upper half
                end else begin
                    new_word[15:0] = store_data[15:0];
                end
            end
            op_sb: begin
                new_word[{byte_off, 3'b000} +: 8] = store_data[7:0];
            end
            default: begin
                new_word = old_word;  // loads leave the word alone
            end
        endcase
    end

endmodule

// File: access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer (
    input  logic                           clkb,
    input  logic                           arst_n,
    // request side
    input  logic                           req,
    input  mem_pkg::ldst_op_t              ldst,
    input  logic [mem_pkg::data_w-1:0]     addrb,
    input  logic [mem_pkg::data_w-1:0]     write_datab,
    // ram side
    output logic [mem_pkg::ram_addr_w-1:0] ram_addrb,
    output logic                           ram_web,
    output logic [mem_pkg::data_w-1:0]     ram_wdata,
    input  logic [mem_pkg::data_w-1:0]     merged_word,
    input  logic [mem_pkg::data_w-1:0]     aligned_rdata,
    // io side
    output logic                           mmio_re,
    output logic                           mmio_we,
    output logic [7:0]                     mmio_addr,
    output logic [mem_pkg::data_w-1:0]     mmio_wdata,
    input  logic [mem_pkg::data_w-1:0]     mmio_rdata,
    // to the formatters
    output mem_pkg::ldst_op_t              op_q,
    output logic [1:0]                     off_q,
    // result
    output logic [mem_pkg::data_w-1:0]     datab,
    output logic                           done,
    output logic                           busy
);
    import mem_pkg::*;

    logic is_load;
    logic is_store;
    logic is_io;
    logic accept;

    logic load_q;   // load result due this cycle
    logic store_q;  // store write phase
    logic io_sel;   // last accepted access went to io

    logic [ram_addr_w-1:0] idx_q;
    logic [7:0]            io_off_q;
    logic [data_w-1:0]     wdata_q;

    always_comb begin
        is_load  = ldst inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
        is_store = ldst inside {op_sb, op_sh, op_sw};
        is_io    = (addrb[data_w-1:16] == io_prefix);
        // nothing is taken during the write phase
        accept   = req & ~busy & (is_load | is_store);
    end

    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            load_q  <= 1'b0;
            store_q <= 1'b0;
            io_sel  <= 1'b0;
            op_q    <= op_none;
        end else begin
            load_q  <= accept & is_load;
            store_q <= accept & is_store;
            if (accept) begin
                io_sel <= is_io;
                op_q   <= ldst;
            end
        end
    end

    // request payload, held for the cycle after acceptance
    always_ff @(posedge clkb) begin
        if (accept) begin
            off_q    <= addrb[1:0];
            idx_q    <= addrb[ram_addr_w+1:2];
            io_off_q <= addrb[7:0];
            wdata_q  <= write_datab;
        end
    end

    // ram: read on acceptance, write back one cycle later
    assign ram_addrb = store_q ? idx_q : addrb[ram_addr_w+1:2];
    assign ram_web   = store_q & ~io_sel;
    assign ram_wdata = merged_word;

    // io: same two-phase shape as ram
    assign mmio_re    = accept & is_load & is_io;
    assign mmio_we    = store_q & io_sel;
    assign mmio_addr  = store_q ? io_off_q : addrb[7:0];
    assign mmio_wdata = wdata_q;  // also feeds the store merge

    assign done  = load_q | store_q;
    assign busy  = store_q;
    assign datab = io_sel ? mmio_rdata : aligned_rdata;

endmodule

// File: mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs (
    input  logic                         clkb,
    input  logic                         arst_n,
    input  logic                         mmio_re,
    input  logic                         mmio_we,
    input  logic [7:0]                   mmio_addr,
    input  logic [mem_pkg::data_w-1:0]   mmio_wdata,
    input  logic [7:0]                   switches,
    output logic [mem_pkg::data_w-1:0]   mmio_rdata,
    output logic [mem_pkg::data_w-1:0]   led_out
);
    import mem_pkg::*;

    logic [data_w-1:0] led_q;

    // led register, any store width writes the whole word
    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            led_q <= '0;
        end else if (mmio_we && (mmio_addr == led_addr[7:0])) begin
            led_q <= mmio_wdata;
        end
    end

    // read data lands one cycle after the request, like the ram
    always_ff @(posedge clkb) begin
        if (mmio_re) begin
            case (mmio_addr)
                switches_addr[7:0]: mmio_rdata <= {{(data_w-8){1'b0}}, switches};
                led_addr[7:0]:      mmio_rdata <= led_q;
                default:            mmio_rdata <= '0;  // unmapped
            endcase
        end
    end

    assign led_out = led_q;

endmodule

// File: dmem_subsystem.sv
`timescale 1ns/1ps

module dmem_subsystem (
    input  logic                         clkb,
    input  logic                         arst_n,
    // instruction fetch
    input  logic [mem_pkg::data_w-1:0]   addra,
    output logic [mem_pkg::data_w-1:0]   dataa,
    // load/store
    input  logic                         req,
    input  mem_pkg::ldst_op_t            ldst,
    input  logic [mem_pkg::data_w-1:0]   addrb,
    input  logic [mem_pkg::data_w-1:0]   write_datab,
    output logic [mem_pkg::data_w-1:0]   datab,
    output logic                         done,
    output logic                         busy,
    // board io
    input  logic [7:0]                   switches,
    output logic [mem_pkg::data_w-1:0]   led_out
);
    import mem_pkg::*;

    logic [ram_addr_w-1:0] ram_addrb;
    logic                  ram_web;
    logic [data_w-1:0]     ram_wdata;
    logic [data_w-1:0]     rdatab;       // raw port b word
    logic [data_w-1:0]     merged_word;
    logic [data_w-1:0]     aligned_rdata;

    logic                  mmio_re;
    logic                  mmio_we;
    logic [7:0]            mmio_addr;
    logic [data_w-1:0]     store_wdata;  // latched store data
    logic [data_w-1:0]     mmio_rdata;

    ldst_op_t              op_q;
    logic [1:0]            off_q;

    dual_port_ram u_ram (
        .clkb        (clkb),
        .addra       (addra[ram_addr_w+1:2]),  // byte to word address
        .dataa       (dataa),
        .addrb       (ram_addrb),
        .web         (ram_web),
        .write_datab (ram_wdata),
        .datab       (rdatab)
    );

    load_align u_load_align (
        .ldst     (op_q),
        .byte_off (off_q),
        .word     (rdatab),
        .result   (aligned_rdata)
    );

    store_merge u_store_merge (
        .ldst       (op_q),
        .byte_off   (off_q),
        .old_word   (rdatab),
        .store_data (store_wdata),
        .new_word   (merged_word)
    );

    access_sequencer u_seq (
        .clkb          (clkb),
        .arst_n        (arst_n),
        .req           (req),
        .ldst          (ldst),
        .addrb         (addrb),
        .write_datab   (write_datab),
        .ram_addrb     (ram_addrb),
        .ram_web       (ram_web),
        .ram_wdata     (ram_wdata),
        .merged_word   (merged_word),
        .aligned_rdata (aligned_rdata),
        .mmio_re       (mmio_re),
        .mmio_we       (mmio_we),
        .mmio_addr     (mmio_addr),
        .mmio_wdata    (store_wdata),
        .mmio_rdata    (mmio_rdata),
        .op_q          (op_q),
        .off_q         (off_q),
        .datab         (datab),
        .done          (done),
        .busy          (busy)
    );

    mmio_regs u_mmio (
        .clkb       (clkb),
        .arst_n     (arst_n),
        .mmio_re    (mmio_re),
        .mmio_we    (mmio_we),
        .mmio_addr  (mmio_addr),
        .mmio_wdata (store_wdata),
        .switches   (switches),
        .mmio_rdata (mmio_rdata),
        .led_out    (led_out)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clkb,
    output logic arst_n
);
    initial clkb = 1'b0;
    always #10 clkb = ~clkb;  // 20 ns period

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clkb);
        @(negedge clkb);
        arst_n = 1'b1;  // release away from the active edge
    end

endmodule

// File: dmem_asserts.sv
`timescale 1ns/1ps

module dmem_asserts (
    input logic                       clkb,
    input logic                       arst_n,
    input logic                       req,
    input mem_pkg::ldst_op_t          ldst,
    input logic [mem_pkg::data_w-1:0] addrb,
    input logic                       busy,
    input logic                       done,
    input logic                       ram_web,
    input logic                       mmio_we,
    input logic [mem_pkg::data_w-1:0] led_out
);
    import mem_pkg::*;

    logic is_store;
    logic accepted;
    logic io_target;

    assign is_store  = ldst inside {op_sb, op_sh, op_sw};
    assign accepted  = req && !busy &&
                       (is_store || (ldst inside {op_lb, op_lh, op_lw, op_lbu, op_lhu}));
    assign io_target = (addrb[data_w-1:16] == io_prefix);

    done_after_accept: assert property (@(posedge clkb) disable iff (!arst_n)
        accepted |=> done)
        else $error("done did not follow an accepted request by one cycle");

    // a write only right after a taken store, and only to the target its address selects
    single_write_target: assert property (@(posedge clkb) disable iff (!arst_n)
        (ram_web || mmio_we) |-> !(ram_web && mmio_we) && $past(accepted && is_store)
                                 && (mmio_we == $past(io_target)))
        else $error("store written to the wrong target or outside its write phase");

    led_after_done: assert property (@(posedge clkb) disable iff (!arst_n)
        !$stable(led_out) |-> $past(done))
        else $error("led register changed outside a store done cycle");

endmodule

bind dmem_subsystem dmem_asserts u_asserts (
    .clkb    (clkb),
    .arst_n  (arst_n),
    .req     (req),
    .ldst    (ldst),
    .addrb   (addrb),
    .busy    (busy),
    .done    (done),
    .ram_web (ram_web),
    .mmio_we (mmio_we),
    .led_out (led_out)
);

// File: dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb;
    import mem_pkg::*;

    localparam int wait_limit = 20;
    localparam int words      = 64;  // test window from word 0

    logic              clkb;
    logic              arst_n;
    logic [data_w-1:0] addra;
    logic [data_w-1:0] dataa;
    logic              req;
    ldst_op_t          ldst;
    logic [data_w-1:0] addrb;
    logic [data_w-1:0] write_datab;
    logic [data_w-1:0] datab;
    logic              done;
    logic              busy;
    logic [7:0]        switches;
    logic [data_w-1:0] led_out;

    logic [data_w-1:0] model_mem [words];
    logic [data_w-1:0] model_led;
    logic [31:0]       rng_state;
    int                err_count;

    tb_clock_gen u_clk (.clkb(clkb), .arst_n(arst_n));

    dmem_subsystem uut (
        .clkb(clkb), .arst_n(arst_n), .addra(addra), .dataa(dataa),
        .req(req), .ldst(ldst), .addrb(addrb), .write_datab(write_datab),
        .datab(datab), .done(done), .busy(busy),
        .switches(switches), .led_out(led_out)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // expected word after a store, built from a lane mask
    function automatic logic [31:0] merge_ref(ldst_op_t op, logic [1:0] off,
                                              logic [31:0] old, logic [31:0] data);
        logic [31:0] mask;
        logic [4:0]  sh;
        sh   = 5'd0;
        mask = 32'h0;
        if (op == op_sw) mask = 32'hffff_ffff;
        if (op == op_sh) begin
            sh   = {off[1], 4'b0000};
            mask = 32'h0000_ffff << sh;
        end
        if (op == op_sb) begin
            sh   = {off, 3'b000};
            mask = 32'h0000_00ff << sh;
        end
        return (old & ~mask) | ((data << sh) & mask);
    endfunction

    function automatic logic [31:0] extend_ref(ldst_op_t op, logic [1:0] off,
                                               logic [31:0] word);
        logic [31:0] v;
        v = word;
        if (op == op_lb || op == op_lbu) begin
            v = (word >> {off, 3'b000}) & 32'h0000_00ff;
            if (op == op_lb && v[7]) v = v | 32'hffff_ff00;
        end
        if (op == op_lh || op == op_lhu) begin
            v = (word >> {off[1], 4'b0000}) & 32'h0000_ffff;
            if (op == op_lh && v[15]) v = v | 32'hffff_0000;
        end
        return v;
    endfunction

    function automatic ldst_op_t rand_load_op(logic [2:0] sel);
        case (sel)
            3'd0:    return op_lb;
            3'd1:    return op_lbu;
            3'd2:    return op_lh;
            3'd3:    return op_lhu;
            default: return op_lw;
        endcase
    endfunction

    task automatic step_cycle();
        @(posedge clkb);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        err_count++;
        $display("timeout while waiting for %s", what);
        $display("** FAIL **");
        $fatal(1, "wait timed out");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            step_cycle();
            n++;
            if (n > wait_limit) report_timeout("busy to clear");
        end
    endtask

    // one port b access, returns in the done cycle
    task automatic mem_access(input ldst_op_t op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        req         = 1'b1;
        ldst        = op;
        addrb       = addr;
        write_datab = wdata;
        wait_idle();  // held while busy
        step_cycle();
        req  = 1'b0;
        ldst = op_none;
        n    = 0;
        while (!done) begin
            step_cycle();
            n++;
            if (n > wait_limit) report_timeout("done after a request");
        end
        rdata = datab;
    endtask

    task automatic ram_store(input ldst_op_t op, input logic [5:0] idx,
                             input logic [1:0] off, input logic [31:0] data);
        logic [31:0] rd;
        model_mem[idx] = merge_ref(op, off, model_mem[idx], data);
        mem_access(op, {24'h0, idx, off}, data, rd);
    endtask

    task automatic ram_load_check(input string name, input ldst_op_t op,
                                  input logic [5:0] idx, input logic [1:0] off);
        logic [31:0] rd;
        mem_access(op, {24'h0, idx, off}, 32'h0, rd);
        check_value(name, extend_ref(op, off, model_mem[idx]), rd);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] old_word;
        logic [5:0]  idx;
        ldst_op_t    pipe_op [8];
        logic [5:0]  pipe_idx [8];
        logic [1:0]  pipe_off [8];
        int          n;

        err_count   = 0;
        rng_state   = 32'h09521d90;
        addra       = '0;
        req         = 1'b0;
        ldst        = op_none;
        addrb       = '0;
        write_datab = '0;
        switches    = '0;
        model_led   = '0;

        n = 0;
        while (arst_n !== 1'b1) begin
            step_cycle();
            n++;
            if (n > 4 * wait_limit) report_timeout("reset release");
        end
        step_cycle();
        check_value("reset done", 32'h0, 32'(done));
        check_value("reset busy", 32'h0, 32'(busy));
        check_value("reset led", 32'h0, led_out);

        // fill the window, then read it back
        for (int i = 0; i < words; i++) ram_store(op_sw, 6'(i), 2'b00, lcg_next());
        for (int i = 0; i < words; i++) ram_load_check("word readback", op_lw, 6'(i), 2'b00);

        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            ram_store(r[6] ? op_sh : op_sb, r[5:0], r[9:8], lcg_next());
            ram_load_check("sub-word merge", op_lw, r[5:0], 2'b00);
        end

        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            ram_load_check("load extend", rand_load_op(r[10:8]), r[5:0], r[12:11]);
        end

        // one load per cycle, results in order
        wait_idle();
        for (int i = 0; i < 8; i++) begin
            r           = lcg_next();
            pipe_op[i]  = rand_load_op(r[10:8]);
            pipe_idx[i] = r[5:0];
            pipe_off[i] = r[12:11];
        end
        for (int i = 0; i < 8; i++) begin
            req   = 1'b1;
            ldst  = pipe_op[i];
            addrb = {24'h0, pipe_idx[i], pipe_off[i]};
            step_cycle();
            check_value("pipelined done", 32'h1, 32'(done));
            check_value("pipelined load",
                        extend_ref(pipe_op[i], pipe_off[i], model_mem[pipe_idx[i]]), datab);
        end
        req  = 1'b0;
        ldst = op_none;

        // load held through the store write phase
        idx = 6'(lcg_next() >> 26);
        ram_store(op_sw, idx, 2'b00, lcg_next());
        check_value("store busy", 32'h1, 32'(busy));
        req   = 1'b1;
        ldst  = op_lw;
        addrb = {24'h0, idx, 2'b00};
        step_cycle();
        check_value("held req not taken", 32'h0, 32'(done));
        step_cycle();
        check_value("held req done", 32'h1, 32'(done));
        check_value("load after store", model_mem[idx], datab);
        req  = 1'b0;
        ldst = op_none;

        for (int i = 0; i < 20; i++) begin
            r     = lcg_next();
            addra = {24'h0, r[5:0], 2'b00};
            step_cycle();
            check_value("fetch read", model_mem[r[5:0]], dataa);
        end

        // fetch of the word under write sees the old value first
        idx      = 6'(lcg_next() >> 26);
        old_word = model_mem[idx];
        ram_store(op_sw, idx, 2'b00, ~old_word);
        addra = {24'h0, idx, 2'b00};
        step_cycle();
        check_value("fetch collision old", old_word, dataa);
        step_cycle();
        check_value("fetch collision new", model_mem[idx], dataa);

        switches = 8'(lcg_next() >> 24);
        mem_access(op_lw, switches_addr, 32'h0, rd);
        check_value("switch read", {24'h0, switches}, rd);

        for (int i = 0; i < 2; i++) begin
            r         = lcg_next();
            model_led = r;  // any width writes the full word
            mem_access(i == 0 ? op_sw : op_sb, led_addr, r, rd);
            step_cycle();
            check_value("led output", model_led, led_out);
            mem_access(op_lw, led_addr, 32'h0, rd);
            check_value("led readback", model_led, rd);
        end

        mem_access(op_lw, 32'hffff_ff08, 32'h0, rd);
        check_value("unmapped io read", 32'h0, rd);

        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            mem_access(op_sw, {16'hffff, 8'h00, 1'b1, r[4:0], 2'b00}, lcg_next(), rd);
        end
        step_cycle();
        check_value("led after io stores", model_led, led_out);
        for (int i = 0; i < words; i++) ram_load_check("ram after io", op_lw, 6'(i), 2'b00);

        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sources.f
mem_pkg.sv
dual_port_ram.sv
load_align.sv
store_merge.sv
access_sequencer.sv
mmio_regs.sv
dmem_subsystem.sv
tb_clock_gen.sv
dmem_asserts.sv
dmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dmem testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module dmem_tb --Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vdmem_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
